/* Makefile */
TOP = tb_lcd_serial

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "sim passed"

clean:
	rm -rf obj_dir

/* clkgen.sv */
// slow clock divider.
// toggles a test clock from the main clock for the led.
`timescale 1ns/10ps

module clkgen #(
	parameter int MAIN_CLK_HZ = 27_000_000,
	parameter int TEST_CLK_HZ = 1
) (
	input  logic clk,
	input  logic rst,
	output logic clk_out
);

	// main cycles per half period.
	localparam int HALF  = MAIN_CLK_HZ / (2 * TEST_CLK_HZ);
	localparam int CNT_W = $clog2(HALF + 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt     <= '0;
			clk_out <= 1'b0;
		end else if (cnt == CNT_W'(HALF - 1)) begin
			cnt     <= '0;
			clk_out <= ~clk_out;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

/* debounce_button.sv */
// key debouncer for one active-low key.
// two-flop synchroniser, stability counter, press pulse.
`timescale 1ns/10ps

module debounce_button #(
	parameter int DEBOUNCE_CYCLES = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic key_n,
	output logic pressed
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic key_meta, key_sync, key_prev;
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			// released key idles high.
			key_meta <= 1'b1;
			key_sync <= 1'b1;
			key_prev <= 1'b1;
			cnt      <= '0;
			pressed  <= 1'b0;
		end else begin
			key_meta <= key_n;
			key_sync <= key_meta;
			key_prev <= key_sync;
			pressed  <= 1'b0;
			// any edge restarts the count.
			if (key_sync != key_prev) begin
				cnt <= '0;
			end else if (cnt != CNT_W'(DEBOUNCE_CYCLES)) begin
				cnt <= cnt + 1'b1;
				// fires once before the counter saturates.
				if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1) && !key_sync)
					pressed <= 1'b1;
			end
		end
	end

endmodule

/* frame_config.sv */
// frame settings register block.
// live pattern mode and fill colour from the keys.
// copy latched at each frame start.
`timescale 1ns/10ps

module frame_config
	import video_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       pattern_pressed,
	input  logic       colour_pressed,
	input  logic       frame_start,
	output frame_cfg_t cfg,
	output logic       pattern_on
);

	fill_sel_t fill_live;

	always_ff @(posedge clk) begin
		if (rst) begin
			pattern_on <= 1'b0;
			fill_live  <= FILL_RED;
			cfg        <= '{test_pattern: 1'b0, fill: FILL_RED};
		end else begin
			if (pattern_pressed)
				pattern_on <= ~pattern_on;
			// red, green, blue, red.
			if (colour_pressed) begin
				case (fill_live)
					FILL_RED:   fill_live <= FILL_GREEN;
					FILL_GREEN: fill_live <= FILL_BLUE;
					default:    fill_live <= FILL_RED;
				endcase
			end
			// held for the whole frame.
			if (frame_start)
				cfg <= '{test_pattern: pattern_on, fill: fill_live};
		end
	end

endmodule

/* lcd_cmd_pkg.sv */
// serial lcd controller command set.
// bus byte types and the transfer struct for the serializer.
// command codes and init data values.
package lcd_cmd_pkg;

	// raw byte on the serial line.
	typedef logic [7:0] lcd_byte_t;

	// byte as a command or parameter value.
	typedef logic [7:0] lcd_word_t;

	// one byte transfer.
	typedef struct packed {
		logic      is_data;  // low for command bytes.
		lcd_word_t data;
	} lcd_xfer_t;

	// controller commands.
	localparam lcd_word_t CMD_SWRESET = 8'h01;
	localparam lcd_word_t CMD_SLPOUT  = 8'h11;
	localparam lcd_word_t CMD_INVON   = 8'h21;
	localparam lcd_word_t CMD_DISPON  = 8'h29;
	localparam lcd_word_t CMD_CASET   = 8'h2a;
	localparam lcd_word_t CMD_RASET   = 8'h2b;
	localparam lcd_word_t CMD_RAMWR   = 8'h2c;
	localparam lcd_word_t CMD_MADCTL  = 8'h36;
	localparam lcd_word_t CMD_COLMOD  = 8'h3a;

	// parameter bytes.
	localparam lcd_word_t COLMOD_565     = 8'h55;
	localparam lcd_word_t MADCTL_DEFAULT = 8'h00;

endpackage

/* lcd_init_seq.sv */
// panel power-up sequencer.
// reset pulse, settle waits and the init command table.
// pulses done after the last init byte has gone out.
`timescale 1ns/10ps

module lcd_init_seq
	import lcd_cmd_pkg::*;
#(
	parameter int RESET_CYCLES  = 270_000,
	parameter int SETTLE_CYCLES = 3_240_000
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      ser_busy,
	output lcd_xfer_t xfer,
	output logic      start,
	output logic      lcd_rst,
	output logic      done
);

	localparam int DLY_MAX  = (RESET_CYCLES > SETTLE_CYCLES) ? RESET_CYCLES : SETTLE_CYCLES;
	localparam int CNT_W    = $clog2(DLY_MAX + 1);
	localparam int LAST_IDX = 7;

	typedef enum logic [2:0] {
		ST_HOLD,
		ST_SETTLE,
		ST_SEND,
		ST_WAIT,
		ST_DONE,
		ST_IDLE
	} state_t;

	state_t state;
	logic [2:0] idx;
	logic [CNT_W-1:0] cnt;

	// init table.
	always_comb begin
		case (idx)
			3'd0: xfer = '{is_data: 1'b0, data: CMD_SWRESET};
			3'd1: xfer = '{is_data: 1'b0, data: CMD_SLPOUT};
			3'd2: xfer = '{is_data: 1'b0, data: CMD_COLMOD};
			3'd3: xfer = '{is_data: 1'b1, data: COLMOD_565};
			3'd4: xfer = '{is_data: 1'b0, data: CMD_MADCTL};
			3'd5: xfer = '{is_data: 1'b1, data: MADCTL_DEFAULT};
			3'd6: xfer = '{is_data: 1'b0, data: CMD_INVON};
			default: xfer = '{is_data: 1'b0, data: CMD_DISPON};
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_HOLD;
			idx   <= '0;
			cnt   <= '0;
		end else begin
			cnt <= cnt + 1'b1;
			case (state)
				ST_HOLD: if (cnt == CNT_W'(RESET_CYCLES - 1)) begin
					cnt   <= '0;
					state <= ST_SETTLE;
				end
				ST_SETTLE: if (cnt == CNT_W'(SETTLE_CYCLES - 1))
					state <= ST_SEND;
				ST_SEND: if (!ser_busy)
					state <= ST_WAIT;
				ST_WAIT: if (!ser_busy) begin
					// swreset and slpout need settle time.
					if (idx == 3'd0 || idx == 3'd1) begin
						idx   <= idx + 1'b1;
						cnt   <= '0;
						state <= ST_SETTLE;
					end else if (idx == 3'(LAST_IDX)) begin
						state <= ST_DONE;
					end else begin
						idx   <= idx + 1'b1;
						state <= ST_SEND;
					end
				end
				ST_DONE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign start   = (state == ST_SEND) && !ser_busy;
	assign lcd_rst = (state == ST_HOLD);
	assign done    = (state == ST_DONE);

endmodule

/* lcd_serial.sv */
// serial lcd top level.
// key debouncers, lcd controller, led test clock.
// active-low leds: test clock, reset, pattern mode.
`timescale 1ns/10ps

module lcd_serial #(
	parameter int SCREEN_WIDTH    = 240,
	parameter int SCREEN_HEIGHT   = 135,
	parameter int SCREEN_HOFFS    = 40,
	parameter int SCREEN_VOFFS    = 53,
	parameter int RESET_CYCLES    = 270_000,
	parameter int SETTLE_CYCLES   = 3_240_000,
	parameter int DEBOUNCE_CYCLES = 270_000,
	parameter int MAIN_CLK_HZ     = 27_000_000,
	parameter int TEST_CLK_HZ     = 1
) (
	input  logic       clk27,
	input  logic       rst,
	input  logic [1:0] key,
	output logic       serlcd_ena,
	output logic       serlcd_sel,
	output logic       serlcd_cmd,
	output logic       serlcd_clk,
	output logic       serlcd_out,
	output logic [5:0] led
);

	logic colour_pressed, pattern_pressed, pattern_on;
	logic vid_rst, test_clk;

	// key 0 steps the colour.
	debounce_button #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_key0 (
		.clk(clk27), .rst(rst), .key_n(key[0]), .pressed(colour_pressed)
	);

	// key 1 toggles the test pattern.
	debounce_button #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_key1 (
		.clk(clk27), .rst(rst), .key_n(key[1]), .pressed(pattern_pressed)
	);

	video_serial #(
		.SCREEN_WIDTH(SCREEN_WIDTH), .SCREEN_HEIGHT(SCREEN_HEIGHT),
		.SCREEN_HOFFS(SCREEN_HOFFS), .SCREEN_VOFFS(SCREEN_VOFFS),
		.RESET_CYCLES(RESET_CYCLES), .SETTLE_CYCLES(SETTLE_CYCLES)
	) lcd_ctl (
		.clk(clk27), .rst(rst),
		.pattern_pressed(pattern_pressed), .colour_pressed(colour_pressed),
		.pattern_on(pattern_on), .vid_rst(vid_rst), .vid_sel_n(serlcd_sel),
		.vid_cmd(serlcd_cmd), .vid_clk(serlcd_clk), .vid_out(serlcd_out)
	);

	clkgen #(.MAIN_CLK_HZ(MAIN_CLK_HZ), .TEST_CLK_HZ(TEST_CLK_HZ)) clk_test (
		.clk(clk27), .rst(rst), .clk_out(test_clk)
	);

	// panel enable is the inverse of its reset.
	assign serlcd_ena = ~vid_rst;

	// leds light when low.
	assign led[0]   = ~test_clk;
	assign led[1]   = ~rst;
	assign led[2]   = ~pattern_on;
	assign led[5:3] = 3'b111;

endmodule

/* lcd_serializer.sv */
// byte serializer for the lcd bus.
// msb first, two main cycles per bit, low then high serial clock.
// data/command flag and select held for the whole byte.
`timescale 1ns/10ps

module lcd_serializer
	import lcd_cmd_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  lcd_xfer_t xfer,
	output logic      busy,
	output logic      ser_clk,
	output logic      ser_out,
	output logic      ser_cmd,
	output logic      ser_sel_n
);

	lcd_byte_t  shreg;
	logic       phase;
	logic [2:0] bit_idx;

	// payload loaded on start.
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			shreg   <= xfer.data;
			ser_cmd <= xfer.is_data;
		end else if (busy && phase) begin
			// next bit after the sampling edge.
			shreg <= {shreg[6:0], 1'b0};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			phase   <= 1'b0;
			bit_idx <= '0;
		end else if (!busy) begin
			phase   <= 1'b0;
			bit_idx <= '0;
			if (start)
				busy <= 1'b1;
		end else begin
			phase <= ~phase;
			if (phase) begin
				bit_idx <= bit_idx + 1'b1;
				// eighth bit done.
				if (bit_idx == 3'd7)
					busy <= 1'b0;
			end
		end
	end

	// high half of each bit is the panel's sampling edge.
	assign ser_clk   = busy & phase;
	assign ser_out   = shreg[7];
	assign ser_sel_n = ~busy;

endmodule

/* pixel_source.sv */
// pixel byte generator.
// window scan counters, fill or test pattern pixel.
// high byte first, last flag on the final byte.
`timescale 1ns/10ps

module pixel_source
	import lcd_cmd_pkg::*, video_pkg::*;
#(
	parameter int SCREEN_WIDTH  = 240,
	parameter int SCREEN_HEIGHT = 135
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       frame_start,
	input  logic       advance,
	input  frame_cfg_t cfg,
	output lcd_byte_t  data,
	output logic       last
);

	coord_t x, y, xy_sum;
	pixel_t pixel;
	logic   low_half;
	logic   x_end, y_end;

	assign x_end  = (x == coord_t'(SCREEN_WIDTH - 1));
	assign y_end  = (y == coord_t'(SCREEN_HEIGHT - 1));
	assign xy_sum = x + y;

	// x runs fastest with two bytes per pixel.
	always_ff @(posedge clk) begin
		if (rst || frame_start) begin
			x        <= '0;
			y        <= '0;
			low_half <= 1'b0;
		end else if (advance) begin
			low_half <= ~low_half;
			if (low_half) begin
				x <= x_end ? '0 : x + 1'b1;
				if (x_end)
					y <= y_end ? '0 : y + 1'b1;
			end
		end
	end

	always_comb begin
		if (cfg.test_pattern) begin
			// r = x, g = y, b = x+y, truncated.
			pixel = {x[4:0], y[5:0], xy_sum[4:0]};
		end else begin
			case (cfg.fill)
				FILL_GREEN: pixel = 16'h07e0;
				FILL_BLUE:  pixel = 16'h001f;
				default:    pixel = 16'hf800;
			endcase
		end
	end

	assign data = low_half ? pixel[7:0] : pixel[15:8];
	assign last = x_end && y_end && low_half;

endmodule

/* tb.f */
+incdir+.
lcd_cmd_pkg.sv
video_pkg.sv
debounce_button.sv
clkgen.sv
lcd_serializer.sv
lcd_init_seq.sv
frame_config.sv
pixel_source.sv
video_serial.sv
lcd_serial.sv
tb_lcd_serial.sv

/* tb_lcd_ref.svh */
// reference model for the lcd byte stream.
// init command list, window setup bytes, rgb565 pixel rule.
`ifndef TB_LCD_REF_SVH
`define TB_LCD_REF_SVH

// init list in bus order with parameters flagged as data.
function automatic lcd_xfer_t init_step(input int idx);
	lcd_xfer_t x;
	case (idx)
		0: x = '{is_data: 1'b0, data: 8'h01};
		1: x = '{is_data: 1'b0, data: 8'h11};
		2: x = '{is_data: 1'b0, data: 8'h3a};
		3: x = '{is_data: 1'b1, data: 8'h55};
		4: x = '{is_data: 1'b0, data: 8'h36};
		5: x = '{is_data: 1'b1, data: 8'h00};
		6: x = '{is_data: 1'b0, data: 8'h21};
		default: x = '{is_data: 1'b0, data: 8'h29};
	endcase
	return x;
endfunction

// caset, raset with first and last bound, then ramwr.
function automatic lcd_xfer_t window_step(input int idx);
	coord_t x0, x1, y0, y1;
	lcd_xfer_t x;
	x0 = coord_t'(SCR_HOFFS);
	x1 = coord_t'(SCR_HOFFS + SCR_W - 1);
	y0 = coord_t'(SCR_VOFFS);
	y1 = coord_t'(SCR_VOFFS + SCR_H - 1);
	case (idx)
		0: x = '{is_data: 1'b0, data: 8'h2a};
		1: x = '{is_data: 1'b1, data: x0[15:8]};
		2: x = '{is_data: 1'b1, data: x0[7:0]};
		3: x = '{is_data: 1'b1, data: x1[15:8]};
		4: x = '{is_data: 1'b1, data: x1[7:0]};
		5: x = '{is_data: 1'b0, data: 8'h2b};
		6: x = '{is_data: 1'b1, data: y0[15:8]};
		7: x = '{is_data: 1'b1, data: y0[7:0]};
		8: x = '{is_data: 1'b1, data: y1[15:8]};
		9: x = '{is_data: 1'b1, data: y1[7:0]};
		default: x = '{is_data: 1'b0, data: 8'h2c};
	endcase
	return x;
endfunction

// fill colour or test pattern at window position x, y.
function automatic pixel_t pixel_rule(input logic pattern, input fill_sel_t fill,
		input int x, input int y);
	logic [4:0] r, b;
	logic [5:0] g;
	pixel_t px;
	r = 5'(x % 32);
	g = 6'(y % 64);
	b = 5'((x + y) % 32);
	if (pattern)
		px = {r, g, b};
	else if (fill == FILL_GREEN)
		px = 16'h07e0;
	else if (fill == FILL_BLUE)
		px = 16'h001f;
	else
		px = 16'hf800;
	return px;
endfunction

`endif

/* tb_lcd_serial.sv */
// testbench for the serial lcd top level.
// clock, reset, key presses, bus decoder into a byte queue.
// checker against the reference stream, compare tasks, report.
`timescale 1ns/10ps

module tb_lcd_serial
	import lcd_cmd_pkg::*, video_pkg::*;
;

	// small screen and short delays.
	localparam int SCR_W     = 4;
	localparam int SCR_H     = 3;
	localparam int SCR_HOFFS = 40;
	localparam int SCR_VOFFS = 53;
	localparam int DEB_CYC   = 4;
	localparam int NFRAMES   = 6;
	localparam int BYTE_TMO  = 200;
	localparam int FRAME_TMO = 3000;

	logic       clk27 = 1'b0;
	logic       rst;
	logic [1:0] key;
	logic       serlcd_ena, serlcd_sel, serlcd_cmd, serlcd_clk, serlcd_out;
	logic [5:0] led;

	lcd_xfer_t rx_q[$];
	lcd_byte_t rx_byte;
	int        rx_bits = 0;

	// settings the next frame should carry.
	logic      exp_pattern = 1'b0;
	fill_sel_t exp_fill    = FILL_RED;

	int   frames_seen = 0;
	logic timed_out   = 1'b0;
	int   xfer_errors = 0;
	int   pixel_errors = 0;
	int   level_errors = 0;
	int   timeouts = 0;
	int   led0_toggles = 0;
	logic led0_prev = 1'b1;
	int   seed = 32'h4eb8cbb5;

	`include "tb_lcd_ref.svh"

	lcd_serial #(
		.SCREEN_WIDTH(SCR_W), .SCREEN_HEIGHT(SCR_H),
		.SCREEN_HOFFS(SCR_HOFFS), .SCREEN_VOFFS(SCR_VOFFS),
		.RESET_CYCLES(5), .SETTLE_CYCLES(8), .DEBOUNCE_CYCLES(DEB_CYC),
		.MAIN_CLK_HZ(1000), .TEST_CLK_HZ(50)
	) DUT (
		.clk27(clk27), .rst(rst), .key(key),
		.serlcd_ena(serlcd_ena), .serlcd_sel(serlcd_sel), .serlcd_cmd(serlcd_cmd),
		.serlcd_clk(serlcd_clk), .serlcd_out(serlcd_out), .led(led)
	);

	// 20 ns period.
	always #10 clk27 = ~clk27;

	// panel samples msb first on the rising serial clock.
	always @(posedge serlcd_clk) begin
		if (!rst && serlcd_sel === 1'b0) begin
			rx_byte = {rx_byte[6:0], serlcd_out};
			rx_bits = rx_bits + 1;
			if (rx_bits == 8) begin
				rx_q.push_back({serlcd_cmd, rx_byte});
				rx_bits = 0;
			end
		end
	end

	// heartbeat led activity.
	always @(posedge clk27) begin
		led0_prev <= led[0];
		if (!rst && led[0] !== led0_prev)
			led0_toggles <= led0_toggles + 1;
	end

	task automatic check_xfer(input string name, input lcd_xfer_t exp, input lcd_xfer_t act);
		if (!timed_out && act !== exp) begin
			xfer_errors++;
			$display("Error %s: expected %b/%02h, actual %b/%02h",
				name, exp.is_data, exp.data, act.is_data, act.data);
		end
	endtask

	task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
		if (!timed_out && act !== exp) begin
			pixel_errors++;
			$display("Error %s: expected %04h, actual %04h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (!timed_out && act !== exp) begin
			level_errors++;
			$display("Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// next decoded byte or zero once the run has timed out.
	task automatic get_xfer(input string what, output lcd_xfer_t x);
		int n;
		n = 0;
		while (rx_q.size() == 0 && !timed_out) begin
			@(posedge clk27);
			n++;
			if (n > BYTE_TMO) begin
				timeouts++;
				timed_out = 1'b1;
				$display("timeout: no byte came on the bus while waiting for %s", what);
			end
		end
		if (rx_q.size() > 0)
			x = rx_q.pop_front();
		else
			x = '0;
	endtask

	task automatic wait_frames(input int n);
		int cyc;
		cyc = 0;
		while (frames_seen < n && !timed_out) begin
			@(posedge clk27);
			cyc++;
			if (cyc > FRAME_TMO) begin
				timeouts++;
				timed_out = 1'b1;
				$display("timeout: frame %0d never reached its pixel data", n - 1);
			end
		end
	endtask

	// random lead-in then a hold well past the debounce time.
	task automatic press_key(input logic idx);
		int gap;
		gap = $random(seed) & 15;
		repeat (gap + 1) @(posedge clk27);
		#2 key[idx] = 1'b0;
		repeat (DEB_CYC + 8) @(posedge clk27);
		#2 key[idx] = 1'b1;
		repeat (DEB_CYC + 8) @(posedge clk27);
		#2;
	endtask

	// presses land in the pixel phase far from the next frame start.
	task automatic drive_keys();
		wait_frames(1);
		press_key(1'b1);
		exp_pattern = 1'b1;
		check_bit("led2 with pattern on", 1'b0, led[2]);
		wait_frames(2);
		press_key(1'b1);
		exp_pattern = 1'b0;
		check_bit("led2 with pattern off", 1'b1, led[2]);
		wait_frames(3);
		press_key(1'b0);
		exp_fill = FILL_GREEN;
		wait_frames(4);
		press_key(1'b0);
		exp_fill = FILL_BLUE;
		wait_frames(5);
		press_key(1'b0);
		exp_fill = FILL_RED;
	endtask

	task automatic check_stream();
		lcd_xfer_t got, hi, lo;
		logic      pat;
		fill_sel_t fill;
		int        i, f, w, p;
		for (i = 0; i < 8; i++) begin
			get_xfer("init", got);
			if (i == 0)
				check_bit("ena at first byte", 1'b1, serlcd_ena);
			check_xfer($sformatf("init byte %0d", i), init_step(i), got);
		end
		for (f = 0; f < NFRAMES; f++) begin
			for (w = 0; w < 11; w++) begin
				get_xfer("window setup", got);
				// settings in force at caset.
				if (w == 0) begin
					pat  = exp_pattern;
					fill = exp_fill;
				end
				check_xfer($sformatf("frame %0d window byte %0d", f, w), window_step(w), got);
			end
			frames_seen = f + 1;
			for (p = 0; p < SCR_W * SCR_H; p++) begin
				get_xfer("pixel high byte", hi);
				get_xfer("pixel low byte", lo);
				check_bit($sformatf("frame %0d pixel %0d high flag", f, p), 1'b1, hi.is_data);
				check_bit($sformatf("frame %0d pixel %0d low flag", f, p), 1'b1, lo.is_data);
				check_pixel($sformatf("frame %0d pixel %0d", f, p),
					pixel_rule(pat, fill, p % SCR_W, p / SCR_W), {hi.data, lo.data});
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		key = 2'b11;
		@(posedge clk27);
		#2;
		check_bit("led1 in reset", 1'b0, led[1]);
		repeat (2) @(posedge clk27);
		#2;
		// idle bus with the panel held in reset.
		check_bit("sel after reset", 1'b1, serlcd_sel);
		check_bit("serial clock after reset", 1'b0, serlcd_clk);
		check_bit("ena after reset", 1'b0, serlcd_ena);
		rst = 1'b0;
		@(posedge clk27);
		#2;
		check_bit("led1 out of reset", 1'b1, led[1]);
		fork
			check_stream();
			drive_keys();
		join
		check_bit("led0 toggling", 1'b1, led0_toggles > 1);
		check_bit("led1 at end", 1'b1, led[1]);
		check_bit("unused leds off", 1'b1, &led[5:3]);
		$display("errors: xfer %0d, pixel %0d, level %0d, timeouts %0d",
			xfer_errors, pixel_errors, level_errors, timeouts);
		if (xfer_errors + pixel_errors + level_errors + timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* video_pkg.sv */
// video side types.
// rgb565 pixel, window coordinate, fill colour select.
// per-frame settings struct.
package video_pkg;

	// rgb565 pixel with red in the top bits.
	typedef logic [15:0] pixel_t;

	// column or row index and window bound.
	typedef logic [15:0] coord_t;

	// fill colour choice.
	typedef enum logic [1:0] {
		FILL_RED,
		FILL_GREEN,
		FILL_BLUE
	} fill_sel_t;

	// settings fixed for one frame.
	typedef struct packed {
		logic      test_pattern;
		fill_sel_t fill;
	} frame_cfg_t;

endpackage

/* video_serial.sv */
// lcd controller.
// init sequencer first, then endless frames.
// window setup, ramwr and pixel stream into the serializer.
`timescale 1ns/10ps

module video_serial
	import lcd_cmd_pkg::*, video_pkg::*;
#(
	parameter int SCREEN_WIDTH  = 240,
	parameter int SCREEN_HEIGHT = 135,
	parameter int SCREEN_HOFFS  = 40,
	parameter int SCREEN_VOFFS  = 53,
	parameter int RESET_CYCLES  = 270_000,
	parameter int SETTLE_CYCLES = 3_240_000
) (
	input  logic clk,
	input  logic rst,
	input  logic pattern_pressed,
	input  logic colour_pressed,
	output logic pattern_on,
	output logic vid_rst,
	output logic vid_sel_n,
	output logic vid_cmd,
	output logic vid_clk,
	output logic vid_out
);

	// window bounds sent with caset and raset.
	localparam coord_t X_FIRST = coord_t'(SCREEN_HOFFS);
	localparam coord_t X_LAST  = coord_t'(SCREEN_HOFFS + SCREEN_WIDTH - 1);
	localparam coord_t Y_FIRST = coord_t'(SCREEN_VOFFS);
	localparam coord_t Y_LAST  = coord_t'(SCREEN_VOFFS + SCREEN_HEIGHT - 1);

	typedef enum logic [2:0] {
		ST_INIT,
		ST_FRAME,
		ST_WIN_SEND,
		ST_WIN_WAIT,
		ST_PIX_SEND,
		ST_PIX_WAIT
	} state_t;

	state_t     state;
	logic [3:0] widx;
	logic       frame_end;

	lcd_xfer_t  init_xfer, win_xfer, ctl_xfer, ser_xfer;
	logic       init_start, init_done, ctl_start, ser_start, ser_busy;
	logic       frame_start, advance, pix_last;
	lcd_byte_t  pix_data;
	frame_cfg_t cfg;

	lcd_init_seq #(
		.RESET_CYCLES(RESET_CYCLES),
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) init_seq (
		.clk(clk), .rst(rst), .ser_busy(ser_busy),
		.xfer(init_xfer), .start(init_start),
		.lcd_rst(vid_rst), .done(init_done)
	);

	frame_config frame_cfg (
		.clk(clk), .rst(rst),
		.pattern_pressed(pattern_pressed), .colour_pressed(colour_pressed),
		.frame_start(frame_start), .cfg(cfg), .pattern_on(pattern_on)
	);

	pixel_source #(
		.SCREEN_WIDTH(SCREEN_WIDTH),
		.SCREEN_HEIGHT(SCREEN_HEIGHT)
	) pix_src (
		.clk(clk), .rst(rst), .frame_start(frame_start), .advance(advance),
		.cfg(cfg), .data(pix_data), .last(pix_last)
	);

	lcd_serializer ser (
		.clk(clk), .rst(rst), .start(ser_start), .xfer(ser_xfer),
		.busy(ser_busy), .ser_clk(vid_clk), .ser_out(vid_out),
		.ser_cmd(vid_cmd), .ser_sel_n(vid_sel_n)
	);

	// window setup table with bounds high byte first.
	always_comb begin
		case (widx)
			4'd0:    win_xfer = '{is_data: 1'b0, data: CMD_CASET};
			4'd1:    win_xfer = '{is_data: 1'b1, data: X_FIRST[15:8]};
			4'd2:    win_xfer = '{is_data: 1'b1, data: X_FIRST[7:0]};
			4'd3:    win_xfer = '{is_data: 1'b1, data: X_LAST[15:8]};
			4'd4:    win_xfer = '{is_data: 1'b1, data: X_LAST[7:0]};
			4'd5:    win_xfer = '{is_data: 1'b0, data: CMD_RASET};
			4'd6:    win_xfer = '{is_data: 1'b1, data: Y_FIRST[15:8]};
			4'd7:    win_xfer = '{is_data: 1'b1, data: Y_FIRST[7:0]};
			4'd8:    win_xfer = '{is_data: 1'b1, data: Y_LAST[15:8]};
			4'd9:    win_xfer = '{is_data: 1'b1, data: Y_LAST[7:0]};
			default: win_xfer = '{is_data: 1'b0, data: CMD_RAMWR};
		endcase
	end

	always_comb begin
		ctl_start   = 1'b0;
		advance     = 1'b0;
		frame_start = (state == ST_FRAME);
		ctl_xfer    = win_xfer;
		case (state)
			ST_WIN_SEND: ctl_start = !ser_busy;
			ST_PIX_SEND: begin
				ctl_start = !ser_busy;
				// pixel source steps as its byte is taken.
				advance   = !ser_busy;
				ctl_xfer  = '{is_data: 1'b1, data: pix_data};
			end
			default: ctl_start = 1'b0;
		endcase
	end

	// bus belongs to the init sequencer until done.
	assign ser_xfer  = (state == ST_INIT) ? init_xfer : ctl_xfer;
	assign ser_start = init_start | ctl_start;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_INIT;
			widx      <= '0;
			frame_end <= 1'b0;
		end else begin
			case (state)
				ST_INIT: if (init_done)
					state <= ST_FRAME;
				ST_FRAME: begin
					widx  <= '0;
					state <= ST_WIN_SEND;
				end
				ST_WIN_SEND: if (!ser_busy)
					state <= ST_WIN_WAIT;
				ST_WIN_WAIT: if (!ser_busy) begin
					widx  <= widx + 1'b1;
					state <= (widx == 4'd10) ? ST_PIX_SEND : ST_WIN_SEND;
				end
				ST_PIX_SEND: if (!ser_busy) begin
					frame_end <= pix_last;
					state     <= ST_PIX_WAIT;
				end
				ST_PIX_WAIT: if (!ser_busy)
					state <= frame_end ? ST_FRAME : ST_PIX_SEND;
				default: state <= ST_INIT;
			endcase
		end
	end

endmodule
